//--- design/conv_geom_pkg.sv
`default_nettype none

package conv_geom_pkg;

  localparam int CHANNELS = 4;  // input channels, one pe_column each
  localparam int ROWS_IN = 14;  // pixels per column per channel
  localparam int TAPS = 3;  // kernel side
  localparam int ROWS_OUT = ROWS_IN - TAPS + 1;  // valid rows, no padding

  typedef logic [7:0] pixel_t;  // unsigned feature value
  typedef logic signed [7:0] weight_t;  // signed coefficient
  typedef logic signed [16:0] prod_t;  // 9b signed pixel times 8b weight
  typedef logic signed [19:0] chan_psum_t;  // nine products, one channel
  typedef logic signed [21:0] psum_t;  // four channels, no overflow

  // kernel[i][j]: i is the row tap, j the column tap, j = 0 the oldest column
  typedef weight_t [TAPS-1:0][TAPS-1:0] kernel_t;

  typedef struct packed {
    logic load_w;  // latch kernel
    logic shift;  // push pixels into window
    logic sof;  // first column of a frame
    pixel_t [ROWS_IN-1:0] pixels;  // this channel's column
    kernel_t kernel;  // this channel's 3x3 set
  } pe_cmd_t;

endpackage

`default_nettype wire

//--- design/conv_flow_pkg.sv
`default_nettype none

package conv_flow_pkg;

  import conv_geom_pkg::*;

  localparam int BEAT_BITS = CHANNELS * ROWS_IN * $bits(pixel_t);  // 448
  localparam int PAD_BITS = BEAT_BITS - CHANNELS * $bits(kernel_t);  // 160

  typedef enum logic {
    BEAT_COLUMN  = 1'b0,  // one pixel column for all channels
    BEAT_WEIGHTS = 1'b1   // kernel set for all channels
  } beat_kind_e;

  typedef struct packed {
    logic [PAD_BITS-1:0] pad;  // unused upper bits
    kernel_t [CHANNELS-1:0] kernels;  // channel c in slot c
  } weight_view_t;

  // same 448 bits read as pixels or as kernels, kind says which
  typedef union packed {
    pixel_t [CHANNELS-1:0][ROWS_IN-1:0] column;
    weight_view_t weights;
  } beat_payload_u;

  typedef struct packed {
    beat_kind_e kind;
    logic sof;  // meaningful on column beats only
    beat_payload_u payload;
  } in_beat_t;  // 450 bits

  typedef struct packed {
    logic sof;  // first result of a frame
    psum_t [ROWS_OUT-1:0] rows;  // row r in slot r
  } result_t;

endpackage

`default_nettype wire

//--- design/column_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module column_feeder
  import conv_geom_pkg::*, conv_flow_pkg::*;
#(
  parameter int IN_DEPTH = 2  // matches source credits
) (
  input  logic clk,
  input  logic reset,
  input  logic in_valid,
  input  in_beat_t in_beat,
  output logic in_credit,
  input  logic room,  // adder has a slot for one more result
  output pe_cmd_t [CHANNELS-1:0] cmd,
  output logic issue_sof
);

  localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CW = $clog2(IN_DEPTH + 1);

  in_beat_t fifo [IN_DEPTH];  // beat storage, no reset
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  in_beat_t head;
  logic head_col;  // head is a column beat
  logic pop;
  logic [1:0] cols_seen;  // columns issued since sof, saturates
  logic first_res;  // this issue produces the frame's first result
  logic ld_q, sh_q, sof_q;  // command flags
  beat_payload_u payload_q;  // issued payload, decoded per view below
  logic [2:0] sres_q;  // sof delay line, cmd, window, psum stages

  assign head = fifo[rd_ptr];
  assign head_col = (head.kind == BEAT_COLUMN);
  assign pop = (count != '0) && (!head_col || room);  // weights never wait
  assign in_credit = pop;  // slot frees at this edge
  assign first_res = pop && head_col && !head.sof && (cols_seen == 2'd2);

  always_ff @(posedge clk) begin
    if (in_valid) fifo[wr_ptr] <= in_beat;  // credits guarantee a free slot
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (in_valid) wr_ptr <= (wr_ptr == PW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(in_valid) - CW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ld_q <= 1'b0;
      sh_q <= 1'b0;
      sof_q <= 1'b0;
      cols_seen <= '0;
      sres_q <= '0;
    end else begin
      ld_q <= pop && !head_col;
      sh_q <= pop && head_col;
      sof_q <= pop && head_col && head.sof;
      sres_q <= {sres_q[1:0], first_res};  // align with col_valid
      if (pop && head_col) begin
        if (head.sof) cols_seen <= 2'd1;
        else if (cols_seen != 2'd3) cols_seen <= cols_seen + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) payload_q <= head.payload;  // payload only, flags say if valid
  end

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      cmd[c].load_w = ld_q;  // same flags on every channel
      cmd[c].shift = sh_q;
      cmd[c].sof = sof_q;
      cmd[c].pixels = payload_q.column[c];  // pixel view
      cmd[c].kernel = payload_q.weights.kernels[c];  // kernel view
    end
  end

  assign issue_sof = sres_q[2];

endmodule

`default_nettype wire

//--- design/pe_column.sv
`timescale 1ns/1ps
`default_nettype none

module pe_column
  import conv_geom_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  pe_cmd_t cmd,
  output logic col_valid,
  output chan_psum_t [ROWS_OUT-1:0] col_psum
);

  kernel_t kern_q;  // loaded on load_w
  pixel_t [TAPS-1:0][ROWS_IN-1:0] win;  // win[0] oldest column
  logic [1:0] col_cnt;  // columns in window since sof, saturates at 3
  logic fresh_q;  // window just became a full new position
  chan_psum_t [ROWS_OUT-1:0] acc;  // combinational row sums

  // pixel is unsigned, widen with a zero before the signed multiply
  function automatic prod_t mul(input pixel_t p, input weight_t w);
    return $signed({1'b0, p}) * w;
  endfunction

  always_ff @(posedge clk) begin
    if (cmd.load_w) kern_q <= cmd.kernel;
    if (cmd.shift) begin
      win[0] <= win[1];  // oldest drops out
      win[1] <= win[2];
      win[2] <= cmd.pixels;  // newest column
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt <= '0;
      fresh_q <= 1'b0;
    end else begin
      fresh_q <= cmd.shift && !cmd.sof && (col_cnt >= 2'd2);
      if (cmd.shift) begin
        if (cmd.sof) col_cnt <= 2'd1;  // restart window
        else if (col_cnt != 2'd3) col_cnt <= col_cnt + 2'd1;
      end
    end
  end

  // row r covers window rows r..r+2, column tap j on win[j]
  always_comb begin
    for (int r = 0; r < ROWS_OUT; r++) begin
      acc[r] = '0;
      for (int i = 0; i < TAPS; i++) begin
        for (int j = 0; j < TAPS; j++) begin
          acc[r] = acc[r] + chan_psum_t'(mul(win[j][r+i], kern_q[i][j]));
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) col_valid <= 1'b0;
    else col_valid <= fresh_q;  // one cycle after the shift
  end

  always_ff @(posedge clk) begin
    if (fresh_q) col_psum <= acc;  // hold between results
  end

endmodule

`default_nettype wire

//--- design/channel_adder.sv
`timescale 1ns/1ps
`default_nettype none

module channel_adder
  import conv_geom_pkg::*, conv_flow_pkg::*;
#(
  parameter int OUT_DEPTH = 4,  // queue entries
  parameter int OUT_CREDITS = 2  // sink credits after reset
) (
  input  logic clk,
  input  logic reset,
  input  logic [CHANNELS-1:0] col_valid,
  input  chan_psum_t [CHANNELS-1:0][ROWS_OUT-1:0] col_psum,
  input  logic issue_sof,
  output logic room,
  output logic out_valid,
  output result_t out_result,
  input  logic out_credit
);

  // cycles a result is invisible to count, room cycle plus three stages
  localparam int PIPE_LAT = 4;
  localparam int PW = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CW = $clog2(OUT_DEPTH + 1);
  localparam int KW = $clog2(OUT_CREDITS + 1);

  result_t queue [OUT_DEPTH];  // result storage, no reset
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;  // queued results
  logic [KW-1:0] credits;  // sink credits held
  logic push, pop;
  psum_t [ROWS_OUT-1:0] sum;
  result_t new_res;

  assign push = &col_valid;  // channels run in lockstep

  always_comb begin
    for (int r = 0; r < ROWS_OUT; r++) begin
      sum[r] = '0;
      for (int c = 0; c < CHANNELS; c++) begin
        sum[r] = sum[r] + psum_t'($signed(col_psum[c][r]));  // sign extend
      end
    end
  end

  always_comb begin
    new_res.sof = issue_sof;
    new_res.rows = sum;
  end

  // up to PIPE_LAT issued results may not be counted yet
  assign room = (int'(count) + PIPE_LAT) <= OUT_DEPTH;

  assign out_valid = (count != '0) && (credits != '0);
  assign pop = out_valid;  // sink always takes a credited result
  assign out_result = queue[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) queue[wr_ptr] <= new_res;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= KW'(OUT_CREDITS);
    end else begin
      if (push) wr_ptr <= (wr_ptr == PW'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
      credits <= credits + KW'(out_credit) - KW'(pop);  // return and spend
    end
  end

endmodule

`default_nettype wire

//--- design/conv_layer2.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer2
  import conv_geom_pkg::*, conv_flow_pkg::*;
#(
  parameter int IN_DEPTH = 2,
  parameter int OUT_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic clk,
  input  logic reset,
  input  logic in_valid,
  input  in_beat_t in_beat,
  output logic in_credit,
  output logic out_valid,
  output result_t out_result,
  input  logic out_credit
);

  pe_cmd_t [CHANNELS-1:0] cmd;  // per channel command
  logic room;
  logic issue_sof;  // aligned with col_valid
  logic [CHANNELS-1:0] col_valid;
  chan_psum_t [CHANNELS-1:0][ROWS_OUT-1:0] col_psum;

  column_feeder #(
    .IN_DEPTH(IN_DEPTH)
  ) column_feeder_i (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_beat(in_beat),
    .in_credit(in_credit),
    .room(room),
    .cmd(cmd),
    .issue_sof(issue_sof)
  );

  for (genvar c = 0; c < CHANNELS; c++) begin : g_pe
    pe_column pe_column_i (
      .clk(clk),
      .reset(reset),
      .cmd(cmd[c]),
      .col_valid(col_valid[c]),
      .col_psum(col_psum[c])
    );
  end

  channel_adder #(
    .OUT_DEPTH(OUT_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) channel_adder_i (
    .clk(clk),
    .reset(reset),
    .col_valid(col_valid),
    .col_psum(col_psum),
    .issue_sof(issue_sof),
    .room(room),
    .out_valid(out_valid),
    .out_result(out_result),
    .out_credit(out_credit)
  );

endmodule

`default_nettype wire

//--- tb/conv_layer2_props.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer2_props #(
  parameter int OUT_CREDITS = 2
) (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic in_credit,
  input logic out_valid,
  input logic out_credit
);

  int out_cred_m;  // sink credits seen from the ports
  int in_pend_m;  // accepted beats not yet credited back

  always_ff @(posedge clk) begin
    if (reset) begin
      out_cred_m <= OUT_CREDITS;
      in_pend_m <= 0;
    end else begin
      out_cred_m <= out_cred_m + int'(out_credit) - int'(out_valid);
      in_pend_m <= in_pend_m + int'(in_valid) - int'(in_credit);
    end
  end

  send_with_credit: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_cred_m > 0) else $error("out_valid with no output credit held");

  credits_bounded: assert property (@(posedge clk) disable iff (reset)
    out_cred_m <= OUT_CREDITS) else $error("output credits above the sink's share");

  credit_per_beat: assert property (@(posedge clk) disable iff (reset)
    in_credit |-> in_pend_m > 0) else $error("in_credit with no beat left to credit");

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !out_valid && !in_credit) else $error("activity in the cycle after reset");

endmodule

bind conv_layer2 conv_layer2_props #(
  .OUT_CREDITS(OUT_CREDITS)
) conv_layer2_props_i (.*);

`default_nettype wire

//--- tb/tb_conv_layer2.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_layer2
  import conv_geom_pkg::*, conv_flow_pkg::*;
();

  localparam int IN_DEPTH = 2;  // source credits, DUT default
  localparam int OUT_CREDITS = 2;  // sink credits, DUT default
  localparam int LIMIT = 2000;  // cycles per wait
  localparam int NUM_TESTS = 7;

  typedef struct {
    string name;
    int kpat;  // 0 random, 1 all -128, 2 all 127, 3 identity tap on channel 0
    int ncols;  // columns in the frame
    bit reload;  // send a kernel set first
    int stall;  // sink holds credits this many cycles
  } test_t;

  logic clk = 1'b0;
  logic reset;
  logic in_valid;
  in_beat_t in_beat;
  logic in_credit;
  logic out_valid;
  result_t out_result;
  logic out_credit = 1'b0;

  test_t tests [NUM_TESTS];
  result_t exp_q [$];  // expected results in order
  int kern_m [CHANNELS][TAPS][TAPS];  // model kernels, kept across frames
  int win_m [TAPS][CHANNELS][ROWS_IN];  // model window, [0] oldest
  int cycle = 0;
  int stall_end = 0;  // sink stalls while cycle is below this
  int beats_sent = 0;
  int credits_back = 0;
  int results_seen = 0;
  int credits_given = 0;
  int stall_hits = 0;  // results taken during a stall
  int errors = 0;
  int result_errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  bit aborted = 1'b0;

  conv_layer2 conv_layer2_i (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_beat(in_beat),
    .in_credit(in_credit),
    .out_valid(out_valid),
    .out_result(out_result),
    .out_credit(out_credit)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  always @(negedge clk) begin
    if (in_credit) credits_back <= credits_back + 1;  // feeder freed a slot
  end

  // sink returns one credit per result once any stall is over
  always @(posedge clk) begin
    #1;
    if (cycle >= stall_end && results_seen > credits_given) begin
      out_credit = 1'b1;
      credits_given++;
    end else begin
      out_credit = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (!reset && out_valid) begin
      if (cycle < stall_end) stall_hits++;
      assert (results_seen < exp_q.size()) else begin
        $display("result at %0t arrived with no expected result left", $time);
        result_errors++;
      end
      if (results_seen < exp_q.size()) begin
        assert (out_result == exp_q[results_seen]) else begin
          $display("FAILED at %0t: out_result expected %h got %h", $time,
                   exp_q[results_seen], out_result);
          result_errors++;
        end
      end
      results_seen++;
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    errors++;
    aborted = 1'b1;  // stop the remaining tests
  endtask

  task automatic send_beat(input in_beat_t beat);
    int n;
    bit sent;
    n = 0;
    sent = 1'b0;
    while (!aborted && !sent && n < LIMIT) begin
      @(posedge clk);
      #1;
      if (IN_DEPTH - (beats_sent - credits_back) > 0) begin
        in_valid = 1'b1;
        in_beat = beat;
        beats_sent++;
        sent = 1'b1;
      end else begin
        in_valid = 1'b0;  // out of credits
        n++;
      end
    end
    if (!aborted && !sent) report_timeout("an input credit");
  endtask

  function automatic int pick_weight(input int kpat, input int c, input int i, input int j);
    case (kpat)
      1: return -128;
      2: return 127;
      3: return (c == 0 && i == 1 && j == 1) ? 1 : 0;  // centre tap only
      default: return int'($urandom_range(255)) - 128;
    endcase
  endfunction

  task automatic load_weights(input int kpat);
    in_beat_t beat;
    beat = '0;
    beat.kind = BEAT_WEIGHTS;
    for (int c = 0; c < CHANNELS; c++) begin
      for (int i = 0; i < TAPS; i++) begin
        for (int j = 0; j < TAPS; j++) begin
          kern_m[c][i][j] = pick_weight(kpat, c, i, j);
          beat.payload.weights.kernels[c][i][j] = weight_t'(kern_m[c][i][j]);
        end
      end
    end
    send_beat(beat);
  endtask

  task automatic send_column(input int kpat, input int idx);
    in_beat_t beat;
    result_t res;
    int p;
    int sum;
    beat = '0;
    beat.kind = BEAT_COLUMN;
    beat.sof = (idx == 0);
    for (int c = 0; c < CHANNELS; c++) begin
      for (int r = 0; r < ROWS_IN; r++) begin
        p = (kpat == 1 || kpat == 2) ? 255 : int'($urandom_range(255));
        win_m[0][c][r] = win_m[1][c][r];  // slide model window
        win_m[1][c][r] = win_m[2][c][r];
        win_m[2][c][r] = p;
        beat.payload.column[c][r] = pixel_t'(p);
      end
    end
    if (idx >= 2) begin  // window full from the third column on
      res.sof = (idx == 2);
      for (int r = 0; r < ROWS_OUT; r++) begin
        sum = 0;
        for (int c = 0; c < CHANNELS; c++) begin
          for (int i = 0; i < TAPS; i++) begin
            for (int j = 0; j < TAPS; j++) begin
              sum += kern_m[c][i][j] * win_m[j][c][r+i];
            end
          end
        end
        res.rows[r] = psum_t'(sum);
      end
      exp_q.push_back(res);
    end
    send_beat(beat);
  endtask

  task automatic check_quiet();
    repeat (8) begin
      @(negedge clk);
      assert (out_valid == 1'b0) else begin
        $display("FAILED at %0t: out_valid expected 0 got %b", $time, out_valid);
        errors++;
      end
      assert (in_credit == 1'b0) else begin
        $display("FAILED at %0t: in_credit expected 0 got %b", $time, in_credit);
        errors++;
      end
    end
    if (errors == 0) tests_ok++;
    else tests_bad++;
    $display("test %-16s %s", "reset_quiet", (errors == 0) ? "ok" : "with errors");
  endtask

  task automatic run_test(input test_t t);
    int err0;
    int hits0;
    int n;
    err0 = errors + result_errors;
    hits0 = stall_hits;
    @(posedge clk);
    #3;
    stall_end = cycle + t.stall;
    if (t.reload) load_weights(t.kpat);
    for (int k = 0; k < t.ncols; k++) send_column(t.kpat, k);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    n = 0;
    while (!aborted && n < LIMIT && (beats_sent != credits_back ||
           results_seen != exp_q.size() || cycle < stall_end)) begin
      @(posedge clk);
      n++;
    end
    if (!aborted && n == LIMIT) report_timeout("the frame's results");
    repeat (8) @(posedge clk);  // quiet window for stray results
    if (t.stall > 0) begin
      assert (stall_hits - hits0 <= OUT_CREDITS) else begin
        $display("sink got %0d results during its stall, more than its credits",
                 stall_hits - hits0);
        errors++;
      end
    end
    if (errors + result_errors == err0) tests_ok++;
    else tests_bad++;
    $display("test %-16s %s, %0d results so far", t.name,
             (errors + result_errors == err0) ? "ok" : "with errors", results_seen);
  endtask

  initial begin
    void'($urandom(32'h7499));
    reset = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    tests[0] = '{"random_frame", 0, 8, 1'b1, 0};
    tests[1] = '{"short_frame", 0, 2, 1'b0, 0};
    tests[2] = '{"restart_frame", 0, 5, 1'b0, 0};
    tests[3] = '{"extreme_low", 1, 4, 1'b1, 0};
    tests[4] = '{"extreme_high", 2, 4, 1'b1, 0};
    tests[5] = '{"identity_reload", 3, 5, 1'b1, 0};
    tests[6] = '{"stalled_sink", 0, 10, 1'b1, 30};
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    check_quiet();
    for (int k = 0; k < NUM_TESTS && !aborted; k++) run_test(tests[k]);
    $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad,
             errors + result_errors);
    if (errors + result_errors == 0) $display("sim passed");
    else $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/conv_geom_pkg.sv
design/conv_flow_pkg.sv
design/column_feeder.sv
design/pe_column.sv
design/channel_adder.sv
design/conv_layer2.sv
tb/conv_layer2_props.sv
tb/tb_conv_layer2.sv

//--- run_sim.sh
#!/bin/sh
# build and run the conv_layer2 testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_conv_layer2 -f build.f -o sim_conv_layer2
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_conv_layer2 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
